// ==== hw/byteRam.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module byteRam (
    input  logic                   clk,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    input  logic                   i_we,
    input  logic [7:0]             i_wdata,
    output logic [7:0]             o_rdata
);

    logic [7:0] mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr];
    end

endmodule

// ==== hw/byteSequencer.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module byteSequencer import memPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_ioFull,

    memReq_if.seq                  req,

    output logic [`MEM_ADDR_W-1:0] o_ramAddr,
    output logic                   o_ramWe,
    output logic [7:0]             o_ramWdata,
    input  logic [7:0]             i_ramRdata
);

    seqState_e              state;
    logic [1:0]             cnt;
    logic [1:0]             lastIdx;
    logic [1:0]             rdOffset;

    logic [`MEM_ADDR_W-1:0] baseAddr;
    accessLen_e             lenReg;
    logic [`WORD_W-1:0]     wdataReg;
    logic [`WORD_W-9:0]     partial;

    // index of the final byte
    always_comb begin
        case (lenReg)
            LEN_BYTE: lastIdx = 2'd0;
            LEN_HALF: lastIdx = 2'd1;
            default:  lastIdx = 2'd3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= 2'd0;
        end else if (!i_ioFull) begin
            case (state)
                ST_IDLE: begin
                    if (req.valid) begin
                        cnt   <= 2'd0;
                        state <= req.isStore ? ST_WRITE : ST_READ;
                    end
                end
                ST_READ: begin
                    // cnt stays on the last byte so its address is kept
                    if (cnt == lastIdx) begin
                        state <= ST_DONE_READ;
                    end else begin
                        cnt <= cnt + 2'd1;
                    end
                end
                ST_WRITE: begin
                    if (cnt == lastIdx) begin
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt + 2'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!i_ioFull) begin
            if (state == ST_IDLE && req.valid) begin
                baseAddr <= req.addr;
                lenReg   <= req.len;
                wdataReg <= req.wdata;
            end
            // byte cnt-1 arrives while byte cnt is addressed
            if (state == ST_READ && cnt != 2'd0) begin
                partial[8 * (cnt - 2'd1) +: 8] <= i_ramRdata;
            end
        end
    end

    // during a freeze re-read the previous byte, so the RAM output keeps it
    always_comb begin
        rdOffset = cnt;
        if (i_ioFull && state == ST_READ && cnt != 2'd0) begin
            rdOffset = cnt - 2'd1;
        end
    end

    assign o_ramAddr  = baseAddr + `MEM_ADDR_W'(rdOffset);
    assign o_ramWe    = (state == ST_WRITE) && !i_ioFull;
    assign o_ramWdata = o_ramWe ? wdataReg[8 * cnt +: 8] : 8'h00;

    assign req.busy = (state != ST_IDLE);

    always_comb begin
        req.done  = 1'b0;
        req.rdata = '0;
        if (!i_ioFull) begin
            case (state)
                ST_WRITE: begin
                    req.done = (cnt == lastIdx);
                end
                ST_DONE_READ: begin
                    req.done = 1'b1;
                    // last byte straight from the RAM, upper bytes zero
                    case (lenReg)
                        LEN_BYTE: req.rdata = {{(`WORD_W - 8){1'b0}}, i_ramRdata};
                        LEN_HALF: req.rdata = {{(`WORD_W - 16){1'b0}}, i_ramRdata, partial[7:0]};
                        default:  req.rdata = {i_ramRdata, partial};
                    endcase
                end
                default: begin
                    req.done = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== hw/memArbiter.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module memArbiter import memPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_ioFull,

    input  logic                   i_fetchEn,
    input  logic [`MEM_ADDR_W-1:0] i_fetchAddr,
    output logic                   o_fetchDone,
    output logic [`WORD_W-1:0]     o_fetchInst,

    input  logic                   i_dataEn,
    input  logic                   i_dataStore,
    input  accessLen_e             i_dataLen,
    input  logic [`MEM_ADDR_W-1:0] i_dataAddr,
    input  logic [`WORD_W-1:0]     i_dataWdata,
    output logic                   o_dataDone,
    output logic [`WORD_W-1:0]     o_dataRdata,

    memReq_if.arb                  req
);

    owner_e owner;
    owner_e sel;

    // data wins when both wait in idle, the owner keeps the bus while busy
    always_comb begin
        if (req.busy) begin
            sel = owner;
        end else if (i_dataEn) begin
            sel = OWN_DATA;
        end else begin
            sel = OWN_FETCH;
        end
    end

    assign req.valid   = !req.busy && (i_dataEn || i_fetchEn);
    assign req.isStore = (sel == OWN_DATA) && i_dataStore;
    assign req.len     = (sel == OWN_DATA) ? i_dataLen : LEN_WORD;
    assign req.addr    = (sel == OWN_DATA) ? i_dataAddr : i_fetchAddr;
    assign req.wdata   = (sel == OWN_DATA) ? i_dataWdata : '0;

    // latched on the same edge the sequencer accepts
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_FETCH;
        end else if (!i_ioFull && req.valid) begin
            owner <= sel;
        end
    end

    // result goes to the owner only
    assign o_fetchDone = req.done && (owner == OWN_FETCH);
    assign o_dataDone  = req.done && (owner == OWN_DATA);
    assign o_fetchInst = (owner == OWN_FETCH) ? req.rdata : '0;
    assign o_dataRdata = (owner == OWN_DATA) ? req.rdata : '0;

endmodule

// ==== hw/memPkg.sv ====
package memPkg;

    // number of bytes moved per access
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } accessLen_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_READ      = 2'd1,
        ST_WRITE     = 2'd2,
        ST_DONE_READ = 2'd3
    } seqState_e;

    // requester holding the access in flight
    typedef enum logic {
        OWN_FETCH = 1'b0,
        OWN_DATA  = 1'b1
    } owner_e;

endpackage

// ==== hw/memReq_if.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

interface memReq_if import memPkg::*; ();

    // request side, held until done
    logic                   valid;
    logic                   isStore;
    accessLen_e             len;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`WORD_W-1:0]     wdata;

    // result side
    logic                   busy;
    logic                   done;
    logic [`WORD_W-1:0]     rdata;

    modport arb (
        output valid, isStore, len, addr, wdata,
        input  busy, done, rdata
    );

    modport seq (
        input  valid, isStore, len, addr, wdata,
        output busy, done, rdata
    );

endinterface

// ==== hw/memSubsystem.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module memSubsystem import memPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_ioFull,

    input  logic                   i_fetchEn,
    input  logic [`MEM_ADDR_W-1:0] i_fetchAddr,
    output logic                   o_fetchDone,
    output logic [`WORD_W-1:0]     o_fetchInst,

    input  logic                   i_dataEn,
    input  logic                   i_dataStore,
    input  accessLen_e             i_dataLen,
    input  logic [`MEM_ADDR_W-1:0] i_dataAddr,
    input  logic [`WORD_W-1:0]     i_dataWdata,
    output logic                   o_dataDone,
    output logic [`WORD_W-1:0]     o_dataRdata
);

    logic [`MEM_ADDR_W-1:0] ramAddr;
    logic                   ramWe;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    memReq_if reqBus ();

    memArbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (i_ioFull),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .req         (reqBus.arb)
    );

    byteSequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .i_ioFull   (i_ioFull),
        .req        (reqBus.seq),
        .o_ramAddr  (ramAddr),
        .o_ramWe    (ramWe),
        .o_ramWdata (ramWdata),
        .i_ramRdata (ramRdata)
    );

    byteRam u_ram (
        .clk     (clk),
        .i_addr  (ramAddr),
        .i_we    (ramWe),
        .i_wdata (ramWdata),
        .o_rdata (ramRdata)
    );

endmodule

// ==== hw/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// byte address width, 4 KiB of RAM
`define MEM_ADDR_W 12

`define MEM_DEPTH (1 << `MEM_ADDR_W)

// word seen by both requesters
`define WORD_W 32

`endif

// ==== project.f ====
+incdir+hw
hw/memPkg.sv
hw/memReq_if.sv
hw/byteRam.sv
hw/byteSequencer.sv
hw/memArbiter.sv
hw/memSubsystem.sv
testbench/memSubsystem_sva.sv
testbench/tb_memSubsystem.sv

// ==== testbench/memSubsystem_sva.sv ====
`timescale 1ns/1ps

module memSubsystem_sva import memPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_ioFull,
    input  logic       i_fetchEn,
    input  logic       i_dataEn,
    input  logic       i_dataStore,
    input  accessLen_e i_dataLen,
    input  logic       i_fetchDone,
    input  logic       i_dataDone,
    input  logic       i_valid,
    input  logic       i_busy
);

    int failCount = 0;

    logic accept;
    logic accWordLoad;
    logic accByteLoad;
    logic accWordStore;

    // data wins the grant whenever its enable is high in idle
    assign accept       = i_valid && !i_busy && !i_ioFull;
    assign accWordLoad  = accept && i_dataEn && !i_dataStore && (i_dataLen == LEN_WORD);
    assign accByteLoad  = accept && i_dataEn && !i_dataStore && (i_dataLen == LEN_BYTE);
    assign accWordStore = accept && i_dataEn && i_dataStore && (i_dataLen == LEN_WORD);

    aDoneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_fetchDone && i_dataDone))
        else begin
            $error("fetch and data done are high together");
            failCount++;
        end

    aDataPulse: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |=> !i_dataDone)
        else begin
            $error("data done lasted more than one cycle");
            failCount++;
        end

    aFetchPulse: assert property (@(posedge clk) disable iff (rst)
        i_fetchDone |=> !i_fetchDone)
        else begin
            $error("fetch done lasted more than one cycle");
            failCount++;
        end

    aNoDoneFrozen: assert property (@(posedge clk) disable iff (rst)
        i_ioFull |-> !(i_fetchDone || i_dataDone))
        else begin
            $error("done pulsed while the I/O buffer was full");
            failCount++;
        end

    aDataOwner: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |-> i_dataEn)
        else begin
            $error("data done without a data request");
            failCount++;
        end

    aFetchOwner: assert property (@(posedge clk) disable iff (rst)
        i_fetchDone |-> i_fetchEn)
        else begin
            $error("fetch done without a fetch request");
            failCount++;
        end

    // fixed latencies counted from the acceptance edge
    aWordLoadLat: assert property (@(posedge clk) disable iff (rst)
        accWordLoad ##1 !i_ioFull [*5] |-> i_dataDone)
        else begin
            $error("word load did not finish in 5 cycles");
            failCount++;
        end

    aByteLoadLat: assert property (@(posedge clk) disable iff (rst)
        accByteLoad ##1 !i_ioFull [*2] |-> i_dataDone)
        else begin
            $error("byte load did not finish in 2 cycles");
            failCount++;
        end

    aWordStoreLat: assert property (@(posedge clk) disable iff (rst)
        accWordStore ##1 !i_ioFull [*4] |-> i_dataDone)
        else begin
            $error("word store did not finish in 4 cycles");
            failCount++;
        end

endmodule

// ==== testbench/tb_memSubsystem.sv ====
`timescale 1ns/1ps

`include "mem_config.svh"

module tb_memSubsystem import memPkg::*; ();

    localparam int AW             = `MEM_ADDR_W;
    localparam int NUM_ACCESSES   = 48;
    localparam int STALL_CYCLES   = 12;
    localparam int TIMEOUT_CYCLES = 8 * NUM_ACCESSES + STALL_CYCLES + 100;
    localparam int DONE_LIMIT     = 12;

    logic          clk;
    logic          rst;
    logic          ioFull;
    logic          fetchEn;
    logic [AW-1:0] fetchAddr;
    logic          fetchDone;
    logic [31:0]   fetchInst;
    logic          dataEn;
    logic          dataStore;
    accessLen_e    dataLen;
    logic [AW-1:0] dataAddr;
    logic [31:0]   dataWdata;
    logic          dataDone;
    logic [31:0]   dataRdata;

    logic [31:0]   lfsr;
    logic [7:0]    refMem [`MEM_DEPTH];
    logic [AW-1:0] wordAddr [16];
    logic [AW-1:0] fetchWords [2];
    int            errCount;
    int            testCount;
    int            failedTests;
    int            cycleCount = 0;

    memSubsystem u_memSubsystem (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (ioFull),
        .i_fetchEn   (fetchEn),
        .i_fetchAddr (fetchAddr),
        .o_fetchDone (fetchDone),
        .o_fetchInst (fetchInst),
        .i_dataEn    (dataEn),
        .i_dataStore (dataStore),
        .i_dataLen   (dataLen),
        .i_dataAddr  (dataAddr),
        .i_dataWdata (dataWdata),
        .o_dataDone  (dataDone),
        .o_dataRdata (dataRdata)
    );

    bind memSubsystem memSubsystem_sva u_sva (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (i_ioFull),
        .i_fetchEn   (i_fetchEn),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_fetchDone (o_fetchDone),
        .i_dataDone  (o_dataDone),
        .i_valid     (reqBus.valid),
        .i_busy      (reqBus.busy)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("run exceeded %0d cycles and was stopped", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    function automatic logic [AW-1:0] randWordAddr();
        return AW'(randBits(AW - 2) << 2);
    endfunction

    function automatic logic [AW-1:0] offsetAddr(input logic [AW-1:0] addr, input int k);
        return AW'(addr + k);
    endfunction

    function automatic int byteCount(input accessLen_e len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // little-endian, zero above the last byte
    function automatic logic [31:0] expectWord(input logic [AW-1:0] addr, input accessLen_e len);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < byteCount(len); k++) begin
            value[8 * k +: 8] = refMem[offsetAddr(addr, k)];
        end
        return value;
    endfunction

    function automatic int totalErrors();
        return errCount + u_memSubsystem.u_sva.failCount;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s expected 0x%08h got 0x%08h", name, expected, actual);
            errCount++;
        end
    endtask

    // optional freeze from cycle stallAt for stallLen cycles
    task automatic waitDone(input bit isFetch, input int stallAt, input int stallLen,
                            output logic [31:0] result);
        int cyc;
        bit seen;
        cyc = 0;
        seen = 1'b0;
        result = '0;
        while (!seen && cyc < DONE_LIMIT + stallLen) begin
            @(negedge clk);
            cyc++;
            if (isFetch) begin
                assert (!dataDone) else begin
                    $display("data done pulsed while a fetch was in flight");
                    errCount++;
                end
            end
            if (isFetch ? fetchDone : dataDone) begin
                seen = 1'b1;
                result = isFetch ? fetchInst : dataRdata;
            end else if (stallLen > 0 && cyc == stallAt) begin
                ioFull = 1'b1;
            end else if (stallLen > 0 && cyc == stallAt + stallLen) begin
                ioFull = 1'b0;
            end
        end
        assert (seen) else begin
            $display("no done pulse came from the %s port within %0d cycles",
                     isFetch ? "fetch" : "data", cyc);
            errCount++;
            ioFull = 1'b0;
        end
    endtask

    task automatic doStore(input accessLen_e len, input logic [AW-1:0] addr,
                           input logic [31:0] wdata, input int stallAt, input int stallLen);
        logic [31:0] ignored;
        @(negedge clk);
        dataEn    = 1'b1;
        dataStore = 1'b1;
        dataLen   = len;
        dataAddr  = addr;
        dataWdata = wdata;
        for (int k = 0; k < byteCount(len); k++) begin
            refMem[offsetAddr(addr, k)] = wdata[8 * k +: 8];
        end
        waitDone(1'b0, stallAt, stallLen, ignored);
        @(negedge clk);
        dataEn = 1'b0;
    endtask

    task automatic doLoad(input accessLen_e len, input logic [AW-1:0] addr,
                          input int stallAt, input int stallLen);
        logic [31:0] result;
        @(negedge clk);
        dataEn    = 1'b1;
        dataStore = 1'b0;
        dataLen   = len;
        dataAddr  = addr;
        waitDone(1'b0, stallAt, stallLen, result);
        checkValue("o_dataRdata", expectWord(addr, len), result);
        @(negedge clk);
        dataEn = 1'b0;
    endtask

    task automatic doFetch(input logic [AW-1:0] addr);
        logic [31:0] result;
        @(negedge clk);
        fetchEn   = 1'b1;
        fetchAddr = addr;
        waitDone(1'b1, 0, 0, result);
        checkValue("o_fetchInst", expectWord(addr, LEN_WORD), result);
        @(negedge clk);
        fetchEn = 1'b0;
    endtask

    // both enables rise together, data must finish first
    task automatic doPriority(input logic [AW-1:0] dAddr, input logic [AW-1:0] fAddr);
        bit dataSeen;
        bit fetchSeen;
        int cyc;
        dataSeen = 1'b0;
        fetchSeen = 1'b0;
        cyc = 0;
        @(negedge clk);
        dataEn    = 1'b1;
        dataStore = 1'b0;
        dataLen   = LEN_WORD;
        dataAddr  = dAddr;
        fetchEn   = 1'b1;
        fetchAddr = fAddr;
        while (!fetchSeen && cyc < 2 * DONE_LIMIT) begin
            @(negedge clk);
            cyc++;
            if (dataSeen) begin
                dataEn = 1'b0;
            end
            if (dataDone) begin
                dataSeen = 1'b1;
                checkValue("o_dataRdata", expectWord(dAddr, LEN_WORD), dataRdata);
            end
            if (fetchDone) begin
                fetchSeen = 1'b1;
                assert (dataSeen) else begin
                    $display("fetch finished before the data access that has priority");
                    errCount++;
                end
                checkValue("o_fetchInst", expectWord(fAddr, LEN_WORD), fetchInst);
            end
        end
        assert (dataSeen && fetchSeen) else begin
            $display("the competing data and fetch accesses did not both finish");
            errCount++;
        end
        @(negedge clk);
        dataEn  = 1'b0;
        fetchEn = 1'b0;
    endtask

    task automatic reportTest(input string name, input int errBefore);
        int errs;
        errs = totalErrors() - errBefore;
        testCount++;
        if (errs == 0) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: %0d error(s)", name, errs);
        end
    endtask

    initial begin
        int errBefore;
        logic [AW-1:0] addr;
        clk         = 1'b0;
        rst         = 1'b1;
        ioFull      = 1'b0;
        fetchEn     = 1'b0;
        fetchAddr   = '0;
        dataEn      = 1'b0;
        dataStore   = 1'b0;
        dataLen     = LEN_BYTE;
        dataAddr    = '0;
        dataWdata   = '0;
        lfsr        = 32'h3c63_7f85;
        errCount    = 0;
        testCount   = 0;
        failedTests = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        errBefore = totalErrors();
        for (int i = 0; i < 16; i++) begin
            wordAddr[i] = randWordAddr();
            doStore(LEN_WORD, wordAddr[i], randBits(32), 0, 0);
            doLoad(LEN_WORD, wordAddr[i], 0, 0);
        end
        reportTest("test 1 word store and load", errBefore);

        // byte and half stores merge into an earlier word
        errBefore = totalErrors();
        addr = randWordAddr();
        doStore(LEN_WORD, addr, randBits(32), 0, 0);
        doStore(LEN_BYTE, offsetAddr(addr, 1), randBits(32), 0, 0);
        doStore(LEN_HALF, offsetAddr(addr, 2), randBits(32), 0, 0);
        doLoad(LEN_WORD, addr, 0, 0);
        doLoad(LEN_BYTE, offsetAddr(addr, 1), 0, 0);
        doLoad(LEN_HALF, offsetAddr(addr, 2), 0, 0);
        doLoad(LEN_BYTE, offsetAddr(addr, 3), 0, 0);
        reportTest("test 2 mixed sizes", errBefore);

        errBefore = totalErrors();
        for (int i = 0; i < 2; i++) begin
            fetchWords[i] = randWordAddr();
            doStore(LEN_WORD, fetchWords[i], randBits(32), 0, 0);
        end
        for (int i = 0; i < 2; i++) begin
            doFetch(fetchWords[i]);
        end
        reportTest("test 3 fetch path", errBefore);

        errBefore = totalErrors();
        doPriority(wordAddr[5], fetchWords[1]);
        reportTest("test 4 data over fetch priority", errBefore);

        // freeze for 6 cycles in the middle of a load and of a store
        errBefore = totalErrors();
        doLoad(LEN_WORD, wordAddr[3], 2, 6);
        addr = randWordAddr();
        doStore(LEN_WORD, addr, randBits(32), 2, 6);
        doLoad(LEN_WORD, addr, 0, 0);
        reportTest("test 5 freeze on full buffer", errBefore);

        $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, totalErrors());
        if (totalErrors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
